// File: common/invaders_defines.svh
/* Field and timing constants shared by the player and alien row blocks.
   DEBOUNCE_TICKS must be 2 or more; columns must fit in 5 bits, rows in 4. */
`ifndef INVADERS_DEFINES_SVH
`define INVADERS_DEFINES_SVH

// Playfield size in columns
`define FIELD_COLS 20
`define FIELD_MAX_X 19

// Ship starts mid field
`define SHIP_START_X 10

// Row just above the ship
`define BULLET_START_Y 14

// Single alien row, counted from the top
`define ALIEN_ROW_Y 2

// Consecutive enable ticks a button must read high
`define DEBOUNCE_TICKS 3

`endif

// File: common/invaders_geom_pkg.sv
/* Playfield geometry types. Row 0 is the top of the field. */
`default_nettype none

`include "invaders_defines.svh"

package invaders_geom_pkg;

   // Column 0 is the left edge
   typedef logic [4:0] xcoord_t;

   typedef logic [3:0] ycoord_t;

   // One bit per column, 1 while the alien lives
   typedef logic [`FIELD_COLS-1:0] alien_mask_t;

endpackage

`default_nettype wire

// File: common/invaders_ctrl_pkg.sv
/* Score type and state machine encodings for the player side. */
`default_nettype none

package invaders_ctrl_pkg;

   typedef logic [7:0] score_t;

   typedef enum logic [0:0] {
      BULLET_IDLE,
      BULLET_FLYING
   } bullet_state_t;

   // Released, counting stable highs, waiting for release
   typedef enum logic [1:0] {
      DEB_RELEASED,
      DEB_PRESSING,
      DEB_HELD
   } deb_state_t;

endpackage

`default_nettype wire

// File: player/edge_detector_debouncer.sv
/* One press pulse per clean button press, sampled on enable ticks only.
   No auto repeat; the input must read low on a tick before the next press. */
`default_nettype none

`include "invaders_defines.svh"

module edge_detector_debouncer import invaders_ctrl_pkg::*; (
   input  logic clk_36MHz,
   input  logic reset,
   input  logic i_enable,
   input  logic i_in,
   output logic o_press
);

   localparam int CNT_W = $clog2(`DEBOUNCE_TICKS);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(`DEBOUNCE_TICKS - 1);

   deb_state_t       state;
   logic [CNT_W-1:0] count;

   always_ff @(posedge clk_36MHz)
   begin
      if (!reset)
      begin
         state <= DEB_RELEASED;
         count <= '0;
      end
      else if (i_enable)
      begin
         case (state)
            DEB_RELEASED:
               if (i_in)
               begin
                  state <= DEB_PRESSING;
                  count <= CNT_W'(1);
               end
            DEB_PRESSING:
               if (!i_in)
                  state <= DEB_RELEASED;
               else if (count == LAST)
                  state <= DEB_HELD;
               else
                  count <= count + 1'b1;
            DEB_HELD:
               if (!i_in)
                  state <= DEB_RELEASED;
            default:
               state <= DEB_RELEASED;
         endcase
      end
   end

   // Pulse on the tick that completes the run of highs
   assign o_press = i_enable && i_in && (state == DEB_PRESSING) && (count == LAST);

   a_single_pulse: assert property (@(posedge clk_36MHz) disable iff (!reset)
      o_press |=> !o_press);

endmodule

`default_nettype wire

// File: player/ship.sv
/* Ship column, one step per cleaned press, clamped to the field.
   Presses must already be one clock wide. */
`default_nettype none

`include "invaders_defines.svh"

module ship import invaders_geom_pkg::*; (
   input  logic    clk_36MHz,
   input  logic    reset,
   input  logic    i_left_press,
   input  logic    i_right_press,
   output xcoord_t o_ship_x
);

   localparam xcoord_t MAX_X = xcoord_t'(`FIELD_MAX_X);

   always_ff @(posedge clk_36MHz)
   begin
      if (!reset)
      begin
         o_ship_x <= xcoord_t'(`SHIP_START_X);
      end
      else
      begin
         // Both at once cancel out
         if (i_left_press && !i_right_press && (o_ship_x != '0))
            o_ship_x <= o_ship_x - 1'b1;
         else if (i_right_press && !i_left_press && (o_ship_x != MAX_X))
            o_ship_x <= o_ship_x + 1'b1;
      end
   end

   a_in_field: assert property (@(posedge clk_36MHz) disable iff (!reset)
      o_ship_x <= MAX_X);

endmodule

`default_nettype wire

// File: player/bullet.sv
/* Single bullet; a shot while one is in flight is dropped.
   Position is only meaningful while o_bullet_flying is high. */
`default_nettype none

`include "invaders_defines.svh"

module bullet
   import invaders_geom_pkg::*;
   import invaders_ctrl_pkg::*;
(
   input  logic    clk_36MHz,
   input  logic    reset,
   input  logic    i_enable,
   input  logic    i_shoot_press,
   input  logic    i_hit,
   input  xcoord_t i_ship_x,
   output xcoord_t o_bullet_x,
   output ycoord_t o_bullet_y,
   output logic    o_bullet_flying
);

   bullet_state_t state;
   logic          launch;
   logic          climb;

   assign launch = (state == BULLET_IDLE) && i_shoot_press;
   assign climb  = (state == BULLET_FLYING) && i_enable && !i_hit;

   always_ff @(posedge clk_36MHz)
   begin
      if (!reset)
         state <= BULLET_IDLE;
      else
      begin
         case (state)
            BULLET_IDLE:
               if (i_shoot_press)
                  state <= BULLET_FLYING;
            BULLET_FLYING:
               // Off the top on the tick after row 0
               if (i_hit || (i_enable && (o_bullet_y == '0)))
                  state <= BULLET_IDLE;
            default:
               state <= BULLET_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_36MHz)
   begin
      if (launch)
      begin
         o_bullet_x <= i_ship_x;
         o_bullet_y <= ycoord_t'(`BULLET_START_Y);
      end
      else if (climb && (o_bullet_y != '0))
         o_bullet_y <= o_bullet_y - 1'b1;
   end

   assign o_bullet_flying = (state == BULLET_FLYING);

   a_x_stable: assert property (@(posedge clk_36MHz) disable iff (!reset)
      (o_bullet_flying && $past(o_bullet_flying)) |-> (o_bullet_x == $past(o_bullet_x)));

endmodule

`default_nettype wire

// File: player/player.sv
/* Player side: button cleanup, ship, bullet and score.
   Score saturates at 255; clear wins over a hit in the same clock. */
`default_nettype none

module player
   import invaders_geom_pkg::*;
   import invaders_ctrl_pkg::*;
(
   input  logic    clk_36MHz,
   input  logic    reset,
   input  logic    i_enable,
   input  logic    i_left,
   input  logic    i_right,
   input  logic    i_start,
   input  logic    i_shoot,
   input  logic    i_clear_score,
   input  logic    i_hit,
   output xcoord_t o_ship_x,
   output xcoord_t o_bullet_x,
   output ycoord_t o_bullet_y,
   output logic    o_bullet_flying,
   output logic    o_start_press,
   output score_t  o_score
);

   logic left_press;
   logic right_press;
   logic shoot_press;

   edge_detector_debouncer left_deb_i (
      .clk_36MHz (clk_36MHz),
      .reset     (reset),
      .i_enable  (i_enable),
      .i_in      (i_left),
      .o_press   (left_press)
   );

   edge_detector_debouncer right_deb_i (
      .clk_36MHz (clk_36MHz),
      .reset     (reset),
      .i_enable  (i_enable),
      .i_in      (i_right),
      .o_press   (right_press)
   );

   // Start goes straight out to the game sequencer
   edge_detector_debouncer start_deb_i (
      .clk_36MHz (clk_36MHz),
      .reset     (reset),
      .i_enable  (i_enable),
      .i_in      (i_start),
      .o_press   (o_start_press)
   );

   edge_detector_debouncer shoot_deb_i (
      .clk_36MHz (clk_36MHz),
      .reset     (reset),
      .i_enable  (i_enable),
      .i_in      (i_shoot),
      .o_press   (shoot_press)
   );

   ship ship_i (
      .clk_36MHz     (clk_36MHz),
      .reset         (reset),
      .i_left_press  (left_press),
      .i_right_press (right_press),
      .o_ship_x      (o_ship_x)
   );

   bullet bullet_i (
      .clk_36MHz       (clk_36MHz),
      .reset           (reset),
      .i_enable        (i_enable),
      .i_shoot_press   (shoot_press),
      .i_hit           (i_hit),
      .i_ship_x        (o_ship_x),
      .o_bullet_x      (o_bullet_x),
      .o_bullet_y      (o_bullet_y),
      .o_bullet_flying (o_bullet_flying)
   );

   always_ff @(posedge clk_36MHz)
   begin
      if (!reset || i_clear_score)
         o_score <= '0;
      else if (i_hit && (o_score != '1))
         o_score <= o_score + 1'b1;
   end

endmodule

`default_nettype wire

// File: hdl/alien_row.sv
/* Alive mask of the single alien row and bullet hit detection.
   o_hit is combinational; the killed bit clears on the same edge. */
`default_nettype none

`include "invaders_defines.svh"

module alien_row import invaders_geom_pkg::*; (
   input  logic        clk_36MHz,
   input  logic        reset,
   input  logic        i_new_wave,
   input  xcoord_t     i_bullet_x,
   input  ycoord_t     i_bullet_y,
   input  logic        i_bullet_flying,
   output logic        o_hit,
   output alien_mask_t o_alive
);

   logic in_row;
   logic in_field;

   assign in_row   = (i_bullet_y == ycoord_t'(`ALIEN_ROW_Y));
   assign in_field = (i_bullet_x <= xcoord_t'(`FIELD_MAX_X));

   // Only a live alien under a flying bullet counts
   assign o_hit = i_bullet_flying && in_row && in_field && o_alive[i_bullet_x];

   always_ff @(posedge clk_36MHz)
   begin
      if (!reset)
      begin
         o_alive <= '1;
      end
      else if (i_new_wave)
      begin
         o_alive <= '1;
      end
      else if (o_hit)
      begin
         o_alive[i_bullet_x] <= 1'b0;
      end
   end

   // Kill ends the flight and the mask bit together
   a_hit_one_clock: assert property (@(posedge clk_36MHz) disable iff (!reset)
      o_hit |=> !o_hit);

endmodule

`default_nettype wire

// File: hdl/invaders_core.sv
/* Player side of the game core. i_enable is the game tick from outside,
   one clock wide; video, alien movement and lives are not handled here. */
`default_nettype none

module invaders_core
   import invaders_geom_pkg::*;
   import invaders_ctrl_pkg::*;
(
   input  logic        clk_36MHz,
   input  logic        reset,
   input  logic        i_enable,
   input  logic        i_left,
   input  logic        i_right,
   input  logic        i_start,
   input  logic        i_shoot,
   input  logic        i_clear_score,
   input  logic        i_new_wave,
   output xcoord_t     o_ship_x,
   output xcoord_t     o_bullet_x,
   output ycoord_t     o_bullet_y,
   output logic        o_bullet_flying,
   output logic        o_start_press,
   output logic        o_hit,
   output score_t      o_score,
   output alien_mask_t o_alive
);

   player player_i (
      .clk_36MHz       (clk_36MHz),
      .reset           (reset),
      .i_enable        (i_enable),
      .i_left          (i_left),
      .i_right         (i_right),
      .i_start         (i_start),
      .i_shoot         (i_shoot),
      .i_clear_score   (i_clear_score),
      .i_hit           (o_hit),
      .o_ship_x        (o_ship_x),
      .o_bullet_x      (o_bullet_x),
      .o_bullet_y      (o_bullet_y),
      .o_bullet_flying (o_bullet_flying),
      .o_start_press   (o_start_press),
      .o_score         (o_score)
   );

   alien_row alien_row_i (
      .clk_36MHz       (clk_36MHz),
      .reset           (reset),
      .i_new_wave      (i_new_wave),
      .i_bullet_x      (o_bullet_x),
      .i_bullet_y      (o_bullet_y),
      .i_bullet_flying (o_bullet_flying),
      .o_hit           (o_hit),
      .o_alive         (o_alive)
   );

endmodule

`default_nettype wire

// File: verification/invaders_core_tb.sv
/* Must run from the project root so the case file path resolves.
   One game tick is four clocks; the case list ends at a line with zero repeats. */
`default_nettype none

`include "invaders_defines.svh"

module invaders_core_tb
   import invaders_geom_pkg::*;
   import invaders_ctrl_pkg::*;
();

   localparam int CLK_HALF      = 4;
   localparam int CLK_PERIOD    = 8;
   localparam int CLKS_PER_TICK = 4;
   localparam int MAX_CASES     = 64;

   logic        clk_36MHz = 1'b0;
   logic        reset;
   logic        i_enable;
   logic        i_left;
   logic        i_right;
   logic        i_start;
   logic        i_shoot;
   logic        i_clear_score;
   logic        i_new_wave;
   xcoord_t     o_ship_x;
   xcoord_t     o_bullet_x;
   ycoord_t     o_bullet_y;
   logic        o_bullet_flying;
   logic        o_start_press;
   logic        o_hit;
   score_t      o_score;
   alien_mask_t o_alive;

   // bb_rr_hh_xx_ss_mmmmm_f per line
   logic [63:0] cases [0:MAX_CASES-1];

   int     case_idx;
   int     start_count = 0;
   int     hit_count = 0;
   int     exp_starts = 0;
   int     exp_hits = 0;
   longint watchdog_time;
   logic   limit_ready = 1'b0;

   invaders_core invaders_core_i (
      .clk_36MHz       (clk_36MHz),
      .reset           (reset),
      .i_enable        (i_enable),
      .i_left          (i_left),
      .i_right         (i_right),
      .i_start         (i_start),
      .i_shoot         (i_shoot),
      .i_clear_score   (i_clear_score),
      .i_new_wave      (i_new_wave),
      .o_ship_x        (o_ship_x),
      .o_bullet_x      (o_bullet_x),
      .o_bullet_y      (o_bullet_y),
      .o_bullet_flying (o_bullet_flying),
      .o_start_press   (o_start_press),
      .o_hit           (o_hit),
      .o_score         (o_score),
      .o_alive         (o_alive)
   );

   always #(CLK_HALF) clk_36MHz = ~clk_36MHz;

   // Pulses are one clock wide, so mid cycle sampling counts each once
   always @(negedge clk_36MHz)
   begin
      if (reset)
      begin
         if (o_start_press)
            start_count++;
         if (o_hit)
            hit_count++;
      end
   end

   task automatic stop_with_failure();
      $display("** FAIL **");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_xcoord(input string name, input xcoord_t got, input xcoord_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h in case %0d", name, got, exp, case_idx);
         stop_with_failure();
      end
   endtask

   task automatic check_ycoord(input string name, input ycoord_t got, input ycoord_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h in case %0d", name, got, exp, case_idx);
         stop_with_failure();
      end
   endtask

   task automatic check_score(input string name, input score_t got, input score_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h in case %0d", name, got, exp, case_idx);
         stop_with_failure();
      end
   endtask

   task automatic check_mask(input string name, input alien_mask_t got,
                             input alien_mask_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h in case %0d", name, got, exp, case_idx);
         stop_with_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s got %h expected %h in case %0d", name, got, exp, case_idx);
         stop_with_failure();
      end
   endtask

   // Each tick is one enable clock followed by three quiet clocks
   task automatic run_ticks(input int count, input logic [5:0] buttons);
      int t;
      for (t = 0; t < count; t++)
      begin
         @(posedge clk_36MHz);
         {i_left, i_right, i_start, i_shoot, i_clear_score, i_new_wave} <= buttons;
         i_enable <= 1'b1;
         @(posedge clk_36MHz);
         i_enable <= 1'b0;
         repeat (2) @(posedge clk_36MHz);
      end
   endtask

   initial
   begin
      wait (limit_ready);
      #(watchdog_time);
      $display("Timeout: the case list did not finish in the expected time");
      stop_with_failure();
   end

   initial
   begin
      logic [63:0] word;
      logic [5:0]  buttons;
      logic [7:0]  reps;
      logic [7:0]  hold;
      xcoord_t     exp_x;
      score_t      exp_score;
      alien_mask_t exp_mask;
      alien_mask_t prev_mask;
      logic        exp_flying;
      xcoord_t     shot_x;
      int          exp_y;
      logic        was_flying;
      int          line_count;
      int          total_ticks;
      int          i;
      int          rep;

      reset         <= 1'b0;
      i_enable      <= 1'b0;
      i_left        <= 1'b0;
      i_right       <= 1'b0;
      i_start       <= 1'b0;
      i_shoot       <= 1'b0;
      i_clear_score <= 1'b0;
      i_new_wave    <= 1'b0;

      for (i = 0; i < MAX_CASES; i++)
         cases[i] = '0;
      $readmemh("verification/invaders_cases.txt", cases);

      // Expected pulse counts and run length come from the case lines
      line_count  = 0;
      total_ticks = 0;
      prev_mask   = '1;
      while ((line_count < MAX_CASES) && (cases[line_count][55:48] != 8'h00))
      begin
         word     = cases[line_count];
         buttons  = word[61:56];
         reps     = word[55:48];
         hold     = word[47:40];
         exp_mask = word[23:4];
         total_ticks += int'(reps) * (int'(hold) + 5);
         if (buttons[3] && (int'(hold) >= `DEBOUNCE_TICKS))
            exp_starts += int'(reps);
         exp_hits += $countones(prev_mask & ~exp_mask);
         prev_mask = exp_mask;
         line_count++;
      end
      if (line_count == 0)
      begin
         $display("No cases found in verification/invaders_cases.txt");
         stop_with_failure();
      end
      watchdog_time = longint'(total_ticks) * CLKS_PER_TICK * CLK_PERIOD
                      + 64 * CLK_PERIOD;
      limit_ready = 1'b1;

      repeat (2) @(posedge clk_36MHz);
      reset <= 1'b1;

      @(negedge clk_36MHz);
      case_idx = 0;
      check_xcoord("o_ship_x", o_ship_x, xcoord_t'(`SHIP_START_X));
      check_score("o_score", o_score, '0);
      check_mask("o_alive", o_alive, '1);
      check_flag("o_bullet_flying", o_bullet_flying, 1'b0);
      check_flag("o_hit", o_hit, 1'b0);
      check_flag("o_start_press", o_start_press, 1'b0);

      was_flying = 1'b0;
      shot_x     = '0;
      exp_y      = 0;
      for (case_idx = 1; case_idx <= line_count; case_idx++)
      begin
         word       = cases[case_idx - 1];
         buttons    = word[61:56];
         reps       = word[55:48];
         hold       = word[47:40];
         exp_x      = word[36:32];
         exp_score  = word[31:24];
         exp_mask   = word[23:4];
         exp_flying = word[0];
         // Bullet row counts down one per tick from the launch tick
         if (exp_flying && !was_flying)
         begin
            shot_x = exp_x;
            exp_y  = `BULLET_START_Y - (int'(hold) - `DEBOUNCE_TICKS + 1)
                     - (int'(reps) - 1) * (int'(hold) + 5);
         end
         else if (exp_flying)
            exp_y = exp_y - int'(reps) * (int'(hold) + 5);
         was_flying = exp_flying;
         for (rep = 1; rep <= int'(reps); rep++)
         begin
            run_ticks(int'(hold), buttons);
            run_ticks(1, 6'b000000);
            if (rep == int'(reps))
            begin
               @(negedge clk_36MHz);
               check_xcoord("o_ship_x", o_ship_x, exp_x);
               check_score("o_score", o_score, exp_score);
               check_mask("o_alive", o_alive, exp_mask);
               check_flag("o_bullet_flying", o_bullet_flying, exp_flying);
               if (exp_flying)
               begin
                  check_xcoord("o_bullet_x", o_bullet_x, shot_x);
                  check_ycoord("o_bullet_y", o_bullet_y, ycoord_t'(exp_y));
               end
            end
            // Released long enough for the next press to start clean
            run_ticks(4, 6'b000000);
         end
      end

      @(negedge clk_36MHz);
      if ((start_count == exp_starts) && (hit_count == exp_hits))
      begin
         $display("** PASS **");
         $finish;
      end
      else
      begin
         if (start_count != exp_starts)
            $display("MISMATCH o_start_press pulses got %h expected %h",
                     start_count, exp_starts);
         if (hit_count != exp_hits)
            $display("MISMATCH o_hit pulses got %h expected %h", hit_count, exp_hits);
         stop_with_failure();
      end
   end

endmodule

`default_nettype wire

// File: verification/invaders_cases.txt
// buttons (left right start shoot clear wave), repeats, hold ticks, ship x, score, alive, flying
// Each repeat: hold, one idle tick, check after the last repeat, four idle ticks
10_01_03_0b_00_fffff_0
10_01_08_0c_00_fffff_0
30_01_03_0c_00_fffff_0
2c_01_02_0c_00_fffff_0
10_07_03_13_00_fffff_0
10_02_03_13_00_fffff_0
20_13_03_00_00_fffff_0
20_01_03_00_00_fffff_0
10_05_03_05_00_fffff_0
04_01_03_05_00_fffff_1
00_01_07_05_01_fffdf_0
04_01_03_05_01_fffdf_1
04_01_03_05_01_fffdf_1
00_01_01_05_01_fffdf_0
02_01_01_05_00_fffdf_0
01_01_01_05_00_fffff_0
08_02_03_05_00_fffff_0
08_01_05_05_00_fffff_0
04_01_03_05_00_fffff_1
00_01_07_05_01_fffdf_0
// End of list
00_00_00_00_00_00000_0

// File: invaders_core.f
+incdir+common
common/invaders_geom_pkg.sv
common/invaders_ctrl_pkg.sv
player/edge_detector_debouncer.sv
player/ship.sv
player/bullet.sv
player/player.sv
hdl/alien_row.sv
hdl/invaders_core.sv
verification/invaders_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= invaders_core_tb
FILELIST  ?= invaders_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
CASES     ?= verification/invaders_cases.txt

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(CASES)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
